// ==== sources.f ====
cpu4_pkg.sv
cpu4_stage_reg.sv
cpu4_fetch.sv
cpu4_decode.sv
cpu4_execute.sv
cpu4_top.sv
tb_clock.sv
tb_cpu4.sv

// ==== Bender.yml ====
package:
  name: cpu4

sources:
  - cpu4_pkg.sv
  - cpu4_stage_reg.sv
  - cpu4_fetch.sv
  - cpu4_decode.sv
  - cpu4_execute.sv
  - cpu4_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_cpu4.sv

// ==== tb_cpu4.sv ====
`timescale 1ns/1ps

module tb_cpu4;

  localparam int HALT_TIMEOUT  = 2000;
  localparam int RESET_TIMEOUT = 10;

  logic        clk;
  logic        arst_n;
  logic        reset_req = 1'b0;
  logic [7:0]  rom_addr;
  logic [11:0] rom_data = '0;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  pwdata;
  logic [3:0]  prdata = '0;
  logic        pready = 1'b0;
  logic        halted;

  logic [11:0] rom [256];
  logic [3:0]  mem [256];
  logic [7:0]  wr_addr_q [$];
  logic [3:0]  wr_data_q [$];
  logic [3:0]  exp_q [$];
  logic [31:0] rng = 32'd42;
  logic        random_waits = 1'b1;
  int          waits_left = 0;
  int          checks = 0;
  int          errors = 0;
  string       cur_test = "";

  tb_clock u_clock (
    .reset_req (reset_req),
    .clk       (clk),
    .arst_n    (arst_n)
  );

  cpu4_top DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .halted   (halted)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ROM and APB memory models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    rom_data <= #1 rom[rom_addr];
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Draws 0 to 3 wait states at the end of each setup phase.
  always @(posedge clk) begin
    if (psel && penable && pready) begin
      if (pwrite) begin
        mem[paddr] = pwdata;
        wr_addr_q.push_back(paddr);
        wr_data_q.push_back(pwdata);
      end
      pready <= #1 1'b0;
    end else if (psel) begin
      if (!penable) begin
        rng = xorshift(rng);
        waits_left = random_waits ? int'(rng[1:0]) : 0;
      end else begin
        waits_left = waits_left - 1;
      end
      if (waits_left <= 0) begin
        pready <= #1 1'b1;
        prdata <= #1 mem[paddr];
      end
    end else begin
      pready <= #1 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", cur_test, expected, actual);
    end
  endtask

  function automatic logic [3:0] fill_value(input logic [7:0] addr);
    return addr[7:4] ^ addr[3:0] ^ 4'h9;
  endfunction

  // C when the conditional jump was taken, 3 when it fell through.
  function automatic logic [3:0] branch_marker(input logic taken);
    return taken ? 4'hC : 4'h3;
  endfunction

  // Three hex digits per word, separated by single spaces.
  task automatic load_program(input string text);
    string word;
    int n;
    int i;
    for (i = 0; i < 256; i++) begin
      rom[i] = 12'hF00;
    end
    n = 0;
    for (i = 0; i + 3 <= text.len(); i += 4) begin
      word = text.substr(i, i + 2);
      rom[n] = word.atohex();
      n++;
    end
  endtask

  // Holds the DUT in reset while memory and ROM are set up.
  task automatic start_test(input string name, input string prog);
    int n;
    int i;
    cur_test = name;
    random_waits = 1'b1;
    reset_req = 1'b1;
    n = 0;
    while (arst_n !== 1'b0 && n < RESET_TIMEOUT) begin
      step();
      n++;
    end
    reset_req = 1'b0;
    if (arst_n !== 1'b0) begin
      $display("Timeout in %s: reset was never asserted", name);
      errors++;
    end
    for (i = 0; i < 256; i++) begin
      mem[i] = fill_value(i);
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    load_program(prog);
  endtask

  task automatic release_reset();
    int n;
    n = 0;
    while (arst_n !== 1'b1 && n < RESET_TIMEOUT) begin
      step();
      n++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timeout in %s: reset was never released", cur_test);
      errors++;
    end
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (halted !== 1'b1 && n < HALT_TIMEOUT) begin
      step();
      n++;
    end
    if (halted !== 1'b1) begin
      $display("Timeout in %s: core did not halt within %0d cycles", cur_test, HALT_TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_cells(input logic [7:0] base);
    int i;
    for (i = 0; i < exp_q.size(); i++) begin
      check(exp_q[i], mem[base + i]);
    end
    exp_q.delete();
  endtask

  // Six flag cases, each storing its result then a branch marker from 0x30 up.
  function automatic string arith_prog();
    string p;
    p = "630 ";
    p = {p, "109 208 800 D00 14C C08 143 840 D00 "};
    p = {p, "14F 300 800 D00 14C B11 143 840 D00 "};
    p = {p, "206 800 D00 14C C19 143 840 D00 "};
    p = {p, "149 400 800 D00 14C B22 143 840 D00 "};
    p = {p, "105 143 500 800 D00 14C B2C 143 840 D00 "};
    p = {p, "24F 300 800 D00 14C C35 143 840 "};
    p = {p, "F00"};
    return p;
  endfunction

  task automatic arith_expected();
    int s;
    logic [3:0] r;
    logic [3:0] b;
    s = 9 + 8;
    exp_q.push_back(4'(s));
    exp_q.push_back(branch_marker(s > 15));
    s = 4'(s) + 15;
    exp_q.push_back(4'(s));
    exp_q.push_back(branch_marker(4'(s) == 0));
    s = 4'(s) + 6;
    exp_q.push_back(4'(s));
    exp_q.push_back(branch_marker(s > 15));
    r = 4'(s) & 4'h9;
    exp_q.push_back(r);
    exp_q.push_back(branch_marker(r == 0));
    r = 4'h5 ^ 4'h3;
    exp_q.push_back(r);
    exp_q.push_back(branch_marker(r == 0));
    // B keeps the last marker, ADDI on B overflows and sets carry.
    b = branch_marker(r == 0) + 4'hF;
    s = r + b;
    exp_q.push_back(4'(s));
    exp_q.push_back(branch_marker(s > 15));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int i;
    start_test("reset_state", "800 860 F00");
    release_reset();
    check(1'b0, psel);
    check(1'b0, penable);
    check(1'b0, pwrite);
    check(1'b0, halted);
    wait_halted();
    check(8'd2, wr_data_q.size());
    for (i = 0; i < wr_data_q.size(); i++) begin
      check(8'h00, wr_addr_q[i]);
      check(4'h0, wr_data_q[i]);
    end
    check(4'h0, mem[8'h00]);
  endtask

  task automatic test_load_store();
    start_test("load_store", "610 720 105 14A 800 860 F00");
    release_reset();
    wait_halted();
    check(4'h5, mem[8'h10]);
    check(4'hA, mem[8'h20]);
    check(8'd2, wr_data_q.size());
  endtask

  task automatic test_arith_flags();
    start_test("arith_flags", arith_prog());
    release_reset();
    wait_halted();
    arith_expected();
    check_cells(8'h30);
  endtask

  // Cells at X are XORed with the key at Y until the result is zero.
  task automatic test_mem_load();
    logic [3:0] cells [4];
    logic [3:0] key;
    logic [3:0] r;
    int i;
    key = 4'hB;
    start_test("mem_load", "640 750 900 960 500 800 D00 B09 A02 F00");
    for (i = 0; i < 4; i++) begin
      cells[i] = key ^ 4'((3 - i) * 5);
      mem[8'h40 + i] = cells[i];
    end
    mem[8'h50] = key;
    release_reset();
    wait_halted();
    i = 0;
    do begin
      r = cells[i] ^ key;
      exp_q.push_back(r);
      i++;
    end while (r != 4'h0 && i < 4);
    exp_q.push_back(fill_value(8'h40 + i));
    check_cells(8'h40);
    check(key, mem[8'h50]);
  endtask

  task automatic test_back_pressure();
    logic [3:0] image [256];
    int writes;
    int i;
    start_test("back_pressure", arith_prog());
    random_waits = 1'b0;
    release_reset();
    wait_halted();
    for (i = 0; i < 256; i++) begin
      image[i] = mem[i];
    end
    writes = wr_data_q.size();
    start_test("back_pressure", arith_prog());
    release_reset();
    wait_halted();
    for (i = 0; i < 256; i++) begin
      check(image[i], mem[i]);
    end
    // Two stores per flag case.
    check(8'd12, writes);
    check(writes, wr_data_q.size());
  endtask

  // B holds the poison value D that the two shadow stores would write.
  task automatic test_branch_flush();
    start_test("branch_flush", "660 14D 107 A06 840 860 800 F00");
    release_reset();
    wait_halted();
    check(8'd1, wr_data_q.size());
    if (wr_data_q.size() > 0) begin
      check(8'h60, wr_addr_q[0]);
      check(4'h7, wr_data_q[0]);
    end
    check(fill_value(8'h00), mem[8'h00]);
  endtask

  initial begin
    test_reset_state();
    test_load_store();
    test_arith_flags();
    test_mem_load();
    test_back_pressure();
    test_branch_flush();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  input  logic reset_req,
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Asserted at once, held over two rising edges, released on a falling edge.
  initial begin
    arst_n = 1'b0;
    forever begin
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(posedge reset_req);
      arst_n = 1'b0;
    end
  end

endmodule

// ==== cpu4_top.sv ====
`timescale 1ns/1ps

module cpu4_top (
  input  logic                             clk,
  input  logic                             arst_n,
  output logic [cpu4_pkg::PC_W-1:0]        rom_addr,
  input  logic [cpu4_pkg::INSTR_W-1:0]     rom_data,
  output logic [cpu4_pkg::ADDR_W-1:0]      paddr,
  output logic                             psel,
  output logic                             penable,
  output logic                             pwrite,
  output logic [cpu4_pkg::DATA_W-1:0]      pwdata,
  input  logic [cpu4_pkg::DATA_W-1:0]      prdata,
  input  logic                             pready,
  output logic                             halted
);

  logic                      stall;
  logic                      redirect;
  logic [cpu4_pkg::PC_W-1:0] redirect_pc;

  cpu4_pkg::fetch_pkt_t      f_pkt;
  logic                      f_valid;
  cpu4_pkg::fetch_pkt_t      d_in_pkt;
  logic                      d_in_valid;
  cpu4_pkg::decode_pkt_t     d_out_pkt;
  logic                      d_out_valid;
  cpu4_pkg::decode_pkt_t     e_pkt;
  logic                      e_valid;

  cpu4_fetch u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .pkt         (f_pkt),
    .pkt_valid   (f_valid)
  );

  // Fetch to decode.
  cpu4_stage_reg #(
    .PAYLOAD_T (cpu4_pkg::fetch_pkt_t)
  ) u_fd_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .hold      (stall),
    .flush     (redirect),
    .in_valid  (f_valid),
    .in_pkt    (f_pkt),
    .out_valid (d_in_valid),
    .out_pkt   (d_in_pkt)
  );

  cpu4_decode u_decode (
    .in_pkt    (d_in_pkt),
    .in_valid  (d_in_valid),
    .out_pkt   (d_out_pkt),
    .out_valid (d_out_valid)
  );

  // Decode to execute.
  cpu4_stage_reg #(
    .PAYLOAD_T (cpu4_pkg::decode_pkt_t)
  ) u_de_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .hold      (stall),
    .flush     (redirect),
    .in_valid  (d_out_valid),
    .in_pkt    (d_out_pkt),
    .out_valid (e_valid),
    .out_pkt   (e_pkt)
  );

  cpu4_execute u_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .pkt         (e_pkt),
    .pkt_valid   (e_valid),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready)
  );

endmodule

// ==== cpu4_execute.sv ====
`timescale 1ns/1ps

module cpu4_execute (
  input  logic                             clk,
  input  logic                             arst_n,
  input  cpu4_pkg::decode_pkt_t            pkt,
  input  logic                             pkt_valid,
  output logic                             stall,
  output logic                             redirect,
  output logic [cpu4_pkg::PC_W-1:0]        redirect_pc,
  output logic                             halted,
  output logic [cpu4_pkg::ADDR_W-1:0]      paddr,
  output logic                             psel,
  output logic                             penable,
  output logic                             pwrite,
  output logic [cpu4_pkg::DATA_W-1:0]      pwdata,
  input  logic [cpu4_pkg::DATA_W-1:0]      prdata,
  input  logic                             pready
);

  logic [cpu4_pkg::DATA_W-1:0] a;
  logic [cpu4_pkg::DATA_W-1:0] b;
  logic [cpu4_pkg::ADDR_W-1:0] x;
  logic [cpu4_pkg::ADDR_W-1:0] y;
  logic                        carry;
  logic                        zero;
  logic                        access;

  logic                        act;
  logic                        is_mem;
  logic                        mem_req;
  logic                        retire;
  logic [cpu4_pkg::DATA_W-1:0] src;
  logic [cpu4_pkg::DATA_W:0]   sum;
  logic [cpu4_pkg::DATA_W-1:0] res;
  logic                        res_we;
  logic                        carry_we;
  logic                        zero_we;
  logic                        taken;
  cpu4_pkg::reg_sel_e          dst;

  assign act     = pkt_valid && !halted;
  assign is_mem  = (pkt.op == cpu4_pkg::OP_ST) || (pkt.op == cpu4_pkg::OP_LD);
  assign mem_req = act && is_mem;
  assign src     = (pkt.rsel == cpu4_pkg::REG_B) ? b : a;

  // Low again in the cycle the transfer completes.
  assign stall  = mem_req && !(access && pready);
  assign retire = act && !stall;

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////

  // Packet is held by the stage register, so address and data stay put.
  assign psel    = mem_req;
  assign penable = access;
  assign pwrite  = mem_req && (pkt.op == cpu4_pkg::OP_ST);
  assign paddr   = (pkt.idx_sel == cpu4_pkg::IDX_Y) ? y : x;
  assign pwdata  = src;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      access <= 1'b0;
    end else begin
      access <= access ? !pready : mem_req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sum      = '0;
    res      = pkt.imm4;
    dst      = pkt.rsel;
    res_we   = 1'b0;
    carry_we = 1'b0;
    zero_we  = 1'b0;
    taken    = 1'b0;
    case (pkt.op)
      cpu4_pkg::OP_LDI: res_we = 1'b1;
      cpu4_pkg::OP_ADDI: begin
        sum      = {1'b0, src} + {1'b0, pkt.imm4};
        res      = sum[cpu4_pkg::DATA_W-1:0];
        res_we   = 1'b1;
        carry_we = 1'b1;
        zero_we  = 1'b1;
      end
      cpu4_pkg::OP_ADD: begin
        sum      = {1'b0, a} + {1'b0, b};
        res      = sum[cpu4_pkg::DATA_W-1:0];
        dst      = cpu4_pkg::REG_A;
        res_we   = 1'b1;
        carry_we = 1'b1;
        zero_we  = 1'b1;
      end
      cpu4_pkg::OP_AND: begin
        res     = a & b;
        dst     = cpu4_pkg::REG_A;
        res_we  = 1'b1;
        zero_we = 1'b1;
      end
      cpu4_pkg::OP_XOR: begin
        res     = a ^ b;
        dst     = cpu4_pkg::REG_A;
        res_we  = 1'b1;
        zero_we = 1'b1;
      end
      cpu4_pkg::OP_LD: begin
        res    = prdata;
        res_we = 1'b1;
      end
      cpu4_pkg::OP_JP:  taken = 1'b1;
      cpu4_pkg::OP_JPZ: taken = zero;
      cpu4_pkg::OP_JPC: taken = carry;
      default: ;
    endcase
  end

  assign redirect    = act && taken;
  assign redirect_pc = pkt.imm8;

  ////////////////////////////////////////////////////////////////////////////
  // Architectural state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a      <= '0;
      b      <= '0;
      x      <= '0;
      y      <= '0;
      carry  <= 1'b0;
      zero   <= 1'b0;
      halted <= 1'b0;
    end else if (retire) begin
      if (res_we) begin
        if (dst == cpu4_pkg::REG_B) begin
          b <= res;
        end else begin
          a <= res;
        end
      end
      if (carry_we) begin
        carry <= sum[cpu4_pkg::DATA_W];
      end
      if (zero_we) begin
        zero <= (res == '0);
      end
      case (pkt.op)
        cpu4_pkg::OP_LDX:  x <= pkt.imm8;
        cpu4_pkg::OP_LDY:  y <= pkt.imm8;
        cpu4_pkg::OP_INCX: x <= x + 1'b1;
        cpu4_pkg::OP_HALT: halted <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== cpu4_decode.sv ====
`timescale 1ns/1ps

module cpu4_decode (
  input  cpu4_pkg::fetch_pkt_t  in_pkt,
  input  logic                  in_valid,
  output cpu4_pkg::decode_pkt_t out_pkt,
  output logic                  out_valid
);

  cpu4_pkg::instr_t instr;
  cpu4_pkg::opcode_e op;
  cpu4_pkg::reg_sel_e rsel;

  assign instr = in_pkt.instr;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode
  ////////////////////////////////////////////////////////////////////////////

  // Anything not listed becomes NOP.
  always_comb begin
    case (instr.opcode)
      cpu4_pkg::OP_LDI,
      cpu4_pkg::OP_ADDI,
      cpu4_pkg::OP_ADD,
      cpu4_pkg::OP_AND,
      cpu4_pkg::OP_XOR,
      cpu4_pkg::OP_LDX,
      cpu4_pkg::OP_LDY,
      cpu4_pkg::OP_ST,
      cpu4_pkg::OP_LD,
      cpu4_pkg::OP_JP,
      cpu4_pkg::OP_JPZ,
      cpu4_pkg::OP_JPC,
      cpu4_pkg::OP_INCX,
      cpu4_pkg::OP_HALT: op = cpu4_pkg::opcode_e'(instr.opcode);
      default:           op = cpu4_pkg::OP_NOP;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand fields
  ////////////////////////////////////////////////////////////////////////////

  // Upper selector codes fold onto A.
  always_comb begin
    if (instr.operand.r.rsel == 2'd1) begin
      rsel = cpu4_pkg::REG_B;
    end else begin
      rsel = cpu4_pkg::REG_A;
    end
  end

  always_comb begin
    out_pkt.op      = op;
    out_pkt.rsel    = rsel;
    out_pkt.idx_sel = instr.operand.r.idx;
    out_pkt.imm4    = instr.operand.r.imm;
    out_pkt.imm8    = instr.operand.imm8;
    out_pkt.pc      = in_pkt.pc;
  end

  assign out_valid = in_valid;

endmodule

// ==== cpu4_fetch.sv ====
`timescale 1ns/1ps

module cpu4_fetch (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             stall,
  input  logic                             redirect,
  input  logic [cpu4_pkg::PC_W-1:0]        redirect_pc,
  input  logic                             halted,
  output logic [cpu4_pkg::PC_W-1:0]        rom_addr,
  input  logic [cpu4_pkg::INSTR_W-1:0]     rom_data,
  output cpu4_pkg::fetch_pkt_t             pkt,
  output logic                             pkt_valid
);

  // Next address to request from the ROM.
  logic [cpu4_pkg::PC_W-1:0] pc;
  // Address of the word now on rom_data.
  logic [cpu4_pkg::PC_W-1:0] req_pc;
  logic                      req_valid;

  // While stalled the ROM re-reads the word being held downstream.
  assign rom_addr = stall ? req_pc : pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= '0;
      req_pc    <= '0;
      req_valid <= 1'b0;
    end else if (redirect) begin
      // Word arriving next cycle is from the wrong path.
      pc        <= redirect_pc;
      req_valid <= 1'b0;
    end else if (!stall) begin
      req_pc    <= pc;
      req_valid <= !halted;
      if (!halted) begin
        pc <= pc + 1'b1;
      end
    end
  end

  assign pkt.instr = rom_data;
  assign pkt.pc    = req_pc;
  assign pkt_valid = req_valid && !halted;

endmodule

// ==== cpu4_stage_reg.sv ====
`timescale 1ns/1ps

module cpu4_stage_reg #(
  parameter type PAYLOAD_T = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     hold,
  input  logic     flush,
  input  logic     in_valid,
  input  PAYLOAD_T in_pkt,
  output logic     out_valid,
  output PAYLOAD_T out_pkt
);

  // Flush wins over hold.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      out_pkt <= in_pkt;
    end
  end

endmodule

// ==== cpu4_pkg.sv ====
package cpu4_pkg;

  localparam int PC_W    = 8;
  localparam int DATA_W  = 4;
  localparam int ADDR_W  = 8;
  localparam int OPC_W   = 4;
  localparam int INSTR_W = OPC_W + ADDR_W;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Code 4'hE is not defined and decodes as NOP.
  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_ADDI = 4'h2,
    OP_ADD  = 4'h3,
    OP_AND  = 4'h4,
    OP_XOR  = 4'h5,
    OP_LDX  = 4'h6,
    OP_LDY  = 4'h7,
    OP_ST   = 4'h8,
    OP_LD   = 4'h9,
    OP_JP   = 4'hA,
    OP_JPZ  = 4'hB,
    OP_JPC  = 4'hC,
    OP_INCX = 4'hD,
    OP_HALT = 4'hF
  } opcode_e;

  typedef enum logic [1:0] {
    REG_A = 2'd0,
    REG_B = 2'd1
  } reg_sel_e;

  // Index selector values.
  localparam logic IDX_X = 1'b0;
  localparam logic IDX_Y = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////////////////////

  // Register form operand.
  typedef struct packed {
    logic [1:0]        rsel;
    logic              idx;
    logic              rsvd;
    logic [DATA_W-1:0] imm;
  } reg_opnd_t;

  typedef union packed {
    reg_opnd_t         r;
    logic [ADDR_W-1:0] imm8;
  } operand_u;

  typedef struct packed {
    logic [OPC_W-1:0] opcode;
    operand_u         operand;
  } instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stage packets
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_t          instr;
    logic [PC_W-1:0] pc;
  } fetch_pkt_t;

  typedef struct packed {
    opcode_e           op;
    reg_sel_e          rsel;
    logic              idx_sel;
    logic [DATA_W-1:0] imm4;
    logic [ADDR_W-1:0] imm8;
    logic [PC_W-1:0]   pc;
  } decode_pkt_t;

endpackage
